/* all.f */
source/isaPkg.sv
source/controlPkg.sv
source/cycleIf.sv
source/stepSequencer.sv
source/flagUnit.sv
source/instrDecoder.sv
source/busCycleControl.sv
source/controlUnit.sv
verif/controlUnit_properties.sv
verif/controlUnitTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module controlUnitTb &&
./obj_dir/VcontrolUnitTb | tee /dev/stderr | grep -qx "all tests passed" &&
echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }

/* verif/controlUnitTb.sv */
// Control unit testbench driving an instruction table with expected controls in a loop
`timescale 1ns/1ps

module controlUnitTb;

   logic                              Clock;
   logic                              nReset;
   logic [isaPkg::InstrWidth-1:0]     OpcodeCondIn;
   logic [isaPkg::FlagCount-1:0]      Flags;
   logic                              nWait;
   logic [controlPkg::AluFnWidth-1:0] AluOp;
   logic                              Op1Sel;
   logic                              Op2Sel;
   logic                              ImmSel;
   logic                              WdSel;
   logic                              Rs1Sel;
   logic [controlPkg::PcSelWidth-1:0] PcSel;
   logic                              AluEn;
   logic                              AluWe;
   logic                              LrEn;
   logic                              LrWe;
   logic                              PcWe;
   logic                              PcEn;
   logic                              IrWe;
   logic                              RegWe;
   logic                              MemEn;
   logic                              nWE;
   logic                              nOE;
   logic                              nME;
   logic                              ENB;
   logic                              ALE;
   logic                              CFlag;

   // Expected word from the top bit down
   // Rs1Sel[11] AluOp[10:7] Op2Sel[6] ImmSel[5] RegWe[4] PcSel[3:2] LrWe[1] LrEn[0]
   logic [7:0]  instrQ[$];
   logic [3:0]  flagsQ[$];
   int          holdQ[$];
   logic [11:0] expectQ[$];

   logic [31:0] lfsr;
   logic        expC;          // Carry held in the status register
   int          testErrors;
   int          failedTests;
   int          testCount;

   controlUnit u_dut (.*);

   initial begin
      Clock = 1'b0;
      forever #50 Clock = ~Clock;
   end

   function automatic logic [31:0] nextLfsr(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
   endfunction

   task automatic drawFlags(output logic [3:0] f);
      for (int i = 0; i < isaPkg::FlagCount; i++) begin
         lfsr = nextLfsr(lfsr);
         f[i] = lfsr[0];
      end
   endtask

   task automatic checkValue(input string name, input int actual, input int expected);
      assert (actual == expected) else begin
         $display("error at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
         testErrors++;
      end
   endtask

   task automatic pushRow(input logic [7:0] instr, input logic [3:0] flagValue,
                          input int hold, input logic [11:0] expected);
      instrQ.push_back(instr);
      flagsQ.push_back(flagValue);
      holdQ.push_back(hold);
      expectQ.push_back(expected);
   endtask

   task automatic addAlu(input logic [4:0] op, input logic [3:0] fn, input logic op2,
                         input logic imm, input logic rs1, input logic regWe);
      pushRow({op, 3'd0}, 4'h0, 0, {rs1, fn, op2, imm, regWe, controlPkg::Pc1, 2'b00});
   endtask

   task automatic addBranch(input logic [2:0] cond, input logic [3:0] flagValue,
                            input logic [1:0] pcSel, input logic lrWe, input logic lrEn);
      pushRow({isaPkg::BRANCH, cond}, flagValue, 0, {1'b0, 4'h0, 3'b000, pcSel, lrWe, lrEn});
   endtask

   task automatic buildTable();
      // Select bits of 1 mean Rd2, short immediate and Rd
      addAlu(isaPkg::ADD,   controlPkg::FnADD,  1'b1, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::ADDI,  controlPkg::FnADD,  1'b0, 1'b1, 1'b0, 1'b1);
      addAlu(isaPkg::ADDIB, controlPkg::FnADD,  1'b0, 1'b0, 1'b1, 1'b1);
      addAlu(isaPkg::ADC,   controlPkg::FnADC,  1'b1, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::ADCI,  controlPkg::FnADC,  1'b0, 1'b1, 1'b0, 1'b1);
      addAlu(isaPkg::SUB,   controlPkg::FnSUB,  1'b1, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::SUBI,  controlPkg::FnSUB,  1'b0, 1'b1, 1'b0, 1'b1);
      addAlu(isaPkg::SUBIB, controlPkg::FnSUB,  1'b0, 1'b0, 1'b1, 1'b1);
      addAlu(isaPkg::SUC,   controlPkg::FnADC,  1'b1, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::SUCI,  controlPkg::FnADC,  1'b0, 1'b1, 1'b0, 1'b1);
      addAlu(isaPkg::NEG,   controlPkg::FnNEG,  1'b0, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::CMP,   controlPkg::FnSUB,  1'b1, 1'b0, 1'b0, 1'b0);
      addAlu(isaPkg::CMPI,  controlPkg::FnSUB,  1'b0, 1'b1, 1'b0, 1'b0);
      addAlu(isaPkg::AND,   controlPkg::FnAND,  1'b1, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::OR,    controlPkg::FnOR,   1'b1, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::XOR,   controlPkg::FnXOR,  1'b1, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::NOR,   controlPkg::FnNOR,  1'b1, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::NAND,  controlPkg::FnNAND, 1'b1, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::NOT,   controlPkg::FnNOT,  1'b0, 1'b0, 1'b0, 1'b1);
      addAlu(isaPkg::LSL,   controlPkg::FnLSL,  1'b0, 1'b1, 1'b0, 1'b1);
      addAlu(isaPkg::LSR,   controlPkg::FnLSR,  1'b0, 1'b1, 1'b0, 1'b1);
      addAlu(isaPkg::ASR,   controlPkg::FnASR,  1'b0, 1'b1, 1'b0, 1'b1);
      addAlu(isaPkg::LUI,   controlPkg::FnLUI,  1'b0, 1'b0, 1'b1, 1'b1);
      addAlu(isaPkg::LLI,   controlPkg::FnLLI,  1'b0, 1'b0, 1'b1, 1'b1);
      // Stored flags are VNZC
      addBranch(isaPkg::BR,  4'b0000, controlPkg::PcAluOut, 1'b0, 1'b0);
      addBranch(isaPkg::BNE, 4'b0000, controlPkg::PcAluOut, 1'b0, 1'b0);
      addBranch(isaPkg::BNE, 4'b0010, controlPkg::Pc1,      1'b0, 1'b0);
      addBranch(isaPkg::BE,  4'b0011, controlPkg::PcAluOut, 1'b0, 1'b0);
      addBranch(isaPkg::BE,  4'b0000, controlPkg::Pc1,      1'b0, 1'b0);
      addBranch(isaPkg::BLT, 4'b0100, controlPkg::PcAluOut, 1'b0, 1'b0);
      addBranch(isaPkg::BLT, 4'b1100, controlPkg::Pc1,      1'b0, 1'b0);
      addBranch(isaPkg::BGE, 4'b1101, controlPkg::PcAluOut, 1'b0, 1'b0);
      addBranch(isaPkg::BGE, 4'b1000, controlPkg::Pc1,      1'b0, 1'b0);
      addBranch(isaPkg::BWL, 4'b0000, controlPkg::PcAluOut, 1'b1, 1'b0);
      addBranch(isaPkg::RET, 4'b0001, controlPkg::PcSysbus, 1'b0, 1'b1);
      pushRow({isaPkg::LDW, 3'd0}, 4'h0, 0, '0);
      pushRow({isaPkg::STW, 3'd0}, 4'h0, 0, '0);
      pushRow({isaPkg::LDW, 3'd0}, 4'h0, 10, '0);   // nWait held low in fetch and execute
   endtask

   task automatic waitFor(input bit pcStrobe, input int limit, output int cycles);
      bit    seen;
      string name;
      seen   = 1'b0;
      cycles = 0;
      name   = pcStrobe ? "PcWe" : "IrWe";
      while (!seen && cycles < limit) begin
         @(negedge Clock);
         cycles++;
         seen = pcStrobe ? PcWe : IrWe;
      end
      assert (seen) else begin
         $display("timeout: %s did not rise within %0d cycles", name, limit);
         testErrors++;
      end
   endtask

   task automatic expectQuiet(input bit pcStrobe, input int cycles);
      string name;
      name = pcStrobe ? "PcWe" : "IrWe";
      for (int i = 0; i < cycles; i++) begin
         @(negedge Clock);
         assert (!(pcStrobe ? PcWe : IrWe)) else begin
            $display("%s rose at %0d ns while nWait was held low", name, $time);
            testErrors++;
         end
      end
   endtask

   // Runs from the negedge of fetch Step0 to the IrWe cycle
   task automatic fetchInstr(input logic [7:0] instr, input logic [3:0] flagValue,
                             input int hold);
      int cycles;
      if (hold > 0) begin
         nWait = 1'b0;
         expectQuiet(1'b0, hold);
         nWait = 1'b1;
         waitFor(1'b0, 1, cycles);   // Step3 right after the stalled Step2
      end else begin
         waitFor(1'b0, 4, cycles);
         checkValue("fetch cycles", cycles + 1, 4);
      end
      OpcodeCondIn = instr;
      Flags        = flagValue;
   endtask

   task automatic runAlu(input int r);
      logic [3:0] f;
      logic [4:0] op;
      op = instrQ[r][isaPkg::OpcodeMsb:isaPkg::OpcodeLsb];
      drawFlags(f);
      fetchInstr(instrQ[r], f, 0);
      @(negedge Clock);
      checkValue("AluOp", int'(AluOp), int'(expectQ[r][10:7]));
      checkValue("Op1Sel", int'(Op1Sel), int'(controlPkg::Op1Rd1));
      checkValue("Op2Sel", int'(Op2Sel), int'(expectQ[r][6]));
      checkValue("ImmSel", int'(ImmSel), int'(expectQ[r][5]));
      checkValue("Rs1Sel", int'(Rs1Sel), int'(expectQ[r][11]));
      checkValue("RegWe", int'(RegWe), int'(expectQ[r][4]));
      checkValue("PcWe", int'(PcWe), 1);
      checkValue("PcSel", int'(PcSel), int'(controlPkg::Pc1));
      if (op != isaPkg::LUI && op != isaPkg::LLI)
         expC = f[isaPkg::FlagC];
      @(negedge Clock);
      checkValue("CFlag", int'(CFlag), int'(expC));
   endtask

   task automatic runBranch(input int r);
      logic [3:0] f;
      fetchInstr({isaPkg::CMP, 3'd0}, flagsQ[r], 0);   // CMP loads the flags under test
      @(negedge Clock);
      expC = flagsQ[r][isaPkg::FlagC];
      @(negedge Clock);
      checkValue("CFlag", int'(CFlag), int'(expC));
      drawFlags(f);
      fetchInstr(instrQ[r], f, 0);
      @(negedge Clock);
      checkValue("PcSel", int'(PcSel), int'(expectQ[r][3:2]));
      checkValue("LrWe", int'(LrWe), int'(expectQ[r][1]));
      checkValue("LrEn", int'(LrEn), int'(expectQ[r][0]));
      checkValue("RegWe", int'(RegWe), 0);
      checkValue("PcWe", int'(PcWe), 1);
      if (instrQ[r][isaPkg::BranchWidth-1:0] != isaPkg::RET)
         checkValue("Op1Sel", int'(Op1Sel), int'(controlPkg::Op1Pc));   // Target is PC plus offset
      @(negedge Clock);
      checkValue("CFlag", int'(CFlag), int'(expC));   // Branch keeps the status
   endtask

   task automatic runMemory(input int r);
      logic [3:0] f;
      int         cycles;
      bit         done;
      bit         isLoad;
      isLoad = instrQ[r][isaPkg::OpcodeMsb:isaPkg::OpcodeLsb] == isaPkg::LDW;
      drawFlags(f);
      fetchInstr(instrQ[r], f, holdQ[r]);
      if (holdQ[r] > 0) begin
         nWait = 1'b0;
         expectQuiet(1'b1, holdQ[r]);
         nWait = 1'b1;
         waitFor(1'b1, 1, cycles);
      end else begin
         done   = 1'b0;
         cycles = 0;
         while (!done && cycles < 8) begin
            @(negedge Clock);
            cycles++;
            done = PcWe;
            checkValue("nME", int'(nME), (cycles == 3 || cycles == 4) ? 0 : 1);   // Steps 2 and 3
            if (!done)
               checkValue("RegWe", int'(RegWe), 0);
         end
         assert (done) else begin
            $display("timeout: PcWe did not rise within 8 execute cycles");
            testErrors++;
         end
         checkValue("execute cycles", cycles, 5);
      end
      checkValue("RegWe", int'(RegWe), int'(isLoad));
      if (isLoad)
         checkValue("WdSel", int'(WdSel), int'(controlPkg::WdSys));
      @(negedge Clock);
      checkValue("CFlag", int'(CFlag), int'(expC));
   endtask

   task automatic checkReset();
      checkValue("RegWe", int'(RegWe), 0);
      checkValue("PcWe", int'(PcWe), 0);
      checkValue("IrWe", int'(IrWe), 0);
      checkValue("LrWe", int'(LrWe), 0);
      checkValue("LrEn", int'(LrEn), 0);
      checkValue("AluWe", int'(AluWe), 0);
      checkValue("AluEn", int'(AluEn), 0);
      checkValue("MemEn", int'(MemEn), 0);
      checkValue("ENB", int'(ENB), 0);
      checkValue("nME", int'(nME), 1);
      checkValue("CFlag", int'(CFlag), 0);
      checkValue("ALE", int'(ALE), 1);   // Fetch Step0 from reset
      checkValue("nWE", int'(nWE), 1);
      checkValue("nOE", int'(nOE), 1);
      checkValue("PcEn", int'(PcEn), 1);
   endtask

   task automatic finishTest(input string name);
      testCount++;
      if (testErrors == 0) begin
         $display("test %0d %s: ok", testCount, name);
      end else begin
         failedTests++;
         $display("test %0d %s: %0d errors", testCount, name, testErrors);
      end
   endtask

   initial begin
      nReset       = 1'b0;
      OpcodeCondIn = '0;
      Flags        = '0;
      nWait        = 1'b1;
      lfsr         = 32'h1aff;
      expC         = 1'b0;
      failedTests  = 0;
      testCount    = 0;
      buildTable();
      repeat (16) @(negedge Clock);
      testErrors = 0;
      checkReset();
      nReset = 1'b1;
      finishTest("reset");
      for (int r = 0; r < instrQ.size(); r++) begin
         testErrors = 0;
         case (instrQ[r][isaPkg::OpcodeMsb:isaPkg::OpcodeLsb])
            isaPkg::BRANCH:           runBranch(r);
            isaPkg::LDW, isaPkg::STW: runMemory(r);
            default:                  runAlu(r);
         endcase
         finishTest($sformatf("instruction %02h", instrQ[r]));
      end
      $display("%0d tests run, %0d failed", testCount, failedTests);
      if (failedTests == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* verif/controlUnit_properties.sv */
// Control unit strobe rules: IrWe pulse width, chip select against address latch, IR vs RF write
`timescale 1ns/1ps

module controlUnitProperties (
   input logic Clock,
   input logic nReset,
   input logic IrWe,
   input logic RegWe,
   input logic nME,
   input logic ALE
);

   irWeSingle: assert property (@(posedge Clock) disable iff (!nReset) IrWe |=> !IrWe)
      else $error("IrWe stayed high for two cycles");

   selectVsLatch: assert property (@(posedge Clock) disable iff (!nReset) !(!nME && ALE))
      else $error("nME low while ALE high");

   irVsRegWrite: assert property (@(posedge Clock) disable iff (!nReset) !(RegWe && IrWe))
      else $error("RegWe and IrWe high together");

endmodule

bind controlUnit controlUnitProperties u_properties (
   .Clock(Clock), .nReset(nReset), .IrWe(IrWe), .RegWe(RegWe), .nME(nME), .ALE(ALE)
);

/* source/controlUnit.sv */
// Control unit top: sequencer, decoder, status flags and memory bus strobes
`timescale 1ns/1ps

module controlUnit (
   input  logic                              Clock,
   input  logic                              nReset,
   input  logic [isaPkg::InstrWidth-1:0]     OpcodeCondIn,
   input  logic [isaPkg::FlagCount-1:0]      Flags,
   input  logic                              nWait,
   output logic [controlPkg::AluFnWidth-1:0] AluOp,
   output logic                              Op1Sel,
   output logic                              Op2Sel,
   output logic                              ImmSel,
   output logic                              WdSel,
   output logic                              Rs1Sel,
   output logic [controlPkg::PcSelWidth-1:0] PcSel,
   output logic                              AluEn,
   output logic                              AluWe,
   output logic                              LrEn,
   output logic                              LrWe,
   output logic                              PcWe,
   output logic                              PcEn,
   output logic                              IrWe,
   output logic                              RegWe,
   output logic                              MemEn,
   output logic                              nWE,
   output logic                              nOE,
   output logic                              nME,
   output logic                              ENB,
   output logic                              ALE,
   output logic                              CFlag
);

   logic                           statusWe;
   logic [isaPkg::BranchWidth-1:0] branchCode;
   logic                           branchTaken;

   cycleIf cyc ();

   stepSequencer u_sequencer (.Clock(Clock), .nReset(nReset), .nWait(nWait), .cyc(cyc));

   instrDecoder u_decoder (
      .OpcodeCondIn(OpcodeCondIn), .cyc(cyc), .branchTaken(branchTaken),
      .statusWe(statusWe), .branchCode(branchCode), .AluOp(AluOp), .Op1Sel(Op1Sel),
      .Op2Sel(Op2Sel), .ImmSel(ImmSel), .WdSel(WdSel), .Rs1Sel(Rs1Sel), .PcSel(PcSel),
      .AluEn(AluEn), .AluWe(AluWe), .LrEn(LrEn), .LrWe(LrWe), .PcWe(PcWe), .PcEn(PcEn),
      .IrWe(IrWe), .RegWe(RegWe)
   );

   flagUnit u_flags (
      .Clock(Clock), .nReset(nReset), .Flags(Flags), .statusWe(statusWe),
      .branchCode(branchCode), .CFlag(CFlag), .branchTaken(branchTaken)
   );

   busCycleControl u_bus (
      .cyc(cyc), .MemEn(MemEn), .nWE(nWE), .nOE(nOE), .nME(nME), .ENB(ENB), .ALE(ALE)
   );

endmodule

/* source/busCycleControl.sv */
// Memory bus strobes and pad enable for instruction fetch and LDW/STW cycles
`timescale 1ns/1ps

module busCycleControl (
   cycleIf.bus  cyc,
   output logic MemEn,
   output logic nWE,
   output logic nOE,
   output logic nME,
   output logic ENB,
   output logic ALE
);

   logic addrStep;
   logic dataStep;
   logic readStep;
   logic writeStep;

   // Execute steps past Step0 only occur for LDW and STW
   always_comb begin
      if (cyc.inFetch) begin
         addrStep  = cyc.step == controlPkg::Step0;
         dataStep  = (cyc.step == controlPkg::Step1) || (cyc.step == controlPkg::Step2);
         readStep  = cyc.step != controlPkg::Step0;
         writeStep = 1'b0;
         ENB       = cyc.step == controlPkg::Step2;
      end else begin
         addrStep  = cyc.step == controlPkg::Step1;
         dataStep  = (cyc.step == controlPkg::Step2) || (cyc.step == controlPkg::Step3);
         readStep  = !cyc.storeOp && (cyc.step >= controlPkg::Step2);
         writeStep = cyc.storeOp && (cyc.step == controlPkg::Step3);
         ENB       = !cyc.storeOp && (cyc.step == controlPkg::Step3);
      end
   end

   assign ALE   = addrStep;
   assign nME   = !dataStep;     // Chip select
   assign MemEn = readStep;      // Pads in toward the core
   assign nOE   = !readStep;
   assign nWE   = !writeStep;

endmodule

/* source/instrDecoder.sv */
// Execute-phase decoder: datapath selects, register and PC enables per opcode and step
`timescale 1ns/1ps

module instrDecoder (
   input  logic [isaPkg::InstrWidth-1:0]     OpcodeCondIn,
   cycleIf.decoder                           cyc,
   input  logic                              branchTaken,
   output logic                              statusWe,
   output logic [isaPkg::BranchWidth-1:0]    branchCode,
   output logic [controlPkg::AluFnWidth-1:0] AluOp,
   output logic                              Op1Sel,
   output logic                              Op2Sel,
   output logic                              ImmSel,
   output logic                              WdSel,
   output logic                              Rs1Sel,
   output logic [controlPkg::PcSelWidth-1:0] PcSel,
   output logic                              AluEn,
   output logic                              AluWe,
   output logic                              LrEn,
   output logic                              LrWe,
   output logic                              PcWe,
   output logic                              PcEn,
   output logic                              IrWe,
   output logic                              RegWe
);

   logic [isaPkg::OpcodeWidth-1:0]    opcode;
   logic [controlPkg::AluFnWidth-1:0] aluFn;
   logic                              isAlu;
   logic                              memOp;
   logic                              storeOp;
   logic                              regOperand;
   logic                              shortImm;
   logic                              byteImm;
   logic                              isCompare;
   logic                              loadImm;

   assign opcode     = OpcodeCondIn[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb];
   assign branchCode = OpcodeCondIn[isaPkg::BranchWidth-1:0];
   assign memOp      = (opcode == isaPkg::LDW) || (opcode == isaPkg::STW);
   assign storeOp    = opcode == isaPkg::STW;
   assign cyc.memoryOp = memOp;
   assign cyc.storeOp  = storeOp;

   assign regOperand = opcode inside {isaPkg::ADD, isaPkg::ADC, isaPkg::SUB, isaPkg::SUC,
                                      isaPkg::CMP, isaPkg::AND, isaPkg::OR, isaPkg::XOR,
                                      isaPkg::NOR, isaPkg::NAND};
   assign shortImm   = opcode inside {isaPkg::ADDI, isaPkg::ADCI, isaPkg::SUBI, isaPkg::SUCI,
                                      isaPkg::CMPI, isaPkg::LSL, isaPkg::LSR, isaPkg::ASR};
   assign byteImm    = opcode inside {isaPkg::ADDIB, isaPkg::SUBIB, isaPkg::LUI, isaPkg::LLI};
   assign isCompare  = (opcode == isaPkg::CMP) || (opcode == isaPkg::CMPI);
   assign loadImm    = (opcode == isaPkg::LUI) || (opcode == isaPkg::LLI);

   always_comb begin
      isAlu = 1'b1;
      case (opcode)
         isaPkg::ADD, isaPkg::ADDI, isaPkg::ADDIB:       aluFn = controlPkg::FnADD;
         isaPkg::ADC, isaPkg::ADCI, isaPkg::SUC, isaPkg::SUCI:
                                                         aluFn = controlPkg::FnADC;
         isaPkg::SUB, isaPkg::SUBI, isaPkg::SUBIB, isaPkg::CMP, isaPkg::CMPI:
                                                         aluFn = controlPkg::FnSUB;
         isaPkg::NEG:  aluFn = controlPkg::FnNEG;
         isaPkg::AND:  aluFn = controlPkg::FnAND;
         isaPkg::OR:   aluFn = controlPkg::FnOR;
         isaPkg::XOR:  aluFn = controlPkg::FnXOR;
         isaPkg::NOR:  aluFn = controlPkg::FnNOR;
         isaPkg::NAND: aluFn = controlPkg::FnNAND;
         isaPkg::NOT:  aluFn = controlPkg::FnNOT;
         isaPkg::LSL:  aluFn = controlPkg::FnLSL;
         isaPkg::LSR:  aluFn = controlPkg::FnLSR;
         isaPkg::ASR:  aluFn = controlPkg::FnASR;
         isaPkg::LUI:  aluFn = controlPkg::FnLUI;
         isaPkg::LLI:  aluFn = controlPkg::FnLLI;
         default: begin
            aluFn = controlPkg::FnA;
            isAlu = 1'b0;
         end
      endcase
   end

   always_comb begin
      AluOp    = controlPkg::FnA;
      Op1Sel   = controlPkg::Op1Rd1;
      Op2Sel   = controlPkg::Op2Imm;
      ImmSel   = controlPkg::ImmLong;
      WdSel    = controlPkg::WdAlu;
      Rs1Sel   = controlPkg::Rs1Ra;
      PcSel    = controlPkg::Pc1;
      AluEn    = 1'b0;
      AluWe    = 1'b0;
      LrEn     = 1'b0;
      LrWe     = 1'b0;
      PcWe     = 1'b0;
      PcEn     = 1'b0;
      IrWe     = 1'b0;
      RegWe    = 1'b0;
      statusWe = 1'b0;
      if (cyc.inFetch) begin
         PcEn = cyc.step == controlPkg::Step0;   // PC out as fetch address
         IrWe = cyc.step == controlPkg::Step3;
      end else if (isAlu) begin
         AluOp    = aluFn;
         Op2Sel   = regOperand ? controlPkg::Op2Rd2 : controlPkg::Op2Imm;
         ImmSel   = shortImm ? controlPkg::ImmShort : controlPkg::ImmLong;
         Rs1Sel   = byteImm ? controlPkg::Rs1Rd : controlPkg::Rs1Ra;
         PcEn     = !loadImm;
         AluEn    = loadImm;
         RegWe    = !isCompare;
         statusWe = !loadImm;
         PcWe     = 1'b1;
      end else if (memOp) begin
         case (cyc.step)
            controlPkg::Step0, controlPkg::Step1: begin   // Base plus offset
               AluOp  = controlPkg::FnADD;
               ImmSel = controlPkg::ImmShort;
               AluEn  = 1'b1;
               AluWe  = cyc.step == controlPkg::Step0;
            end
            controlPkg::Step2: begin
               Rs1Sel = controlPkg::Rs1Rd;   // Store data passes through ALU
               AluWe  = 1'b1;
               AluEn  = 1'b1;
            end
            controlPkg::Step3: AluEn = storeOp;   // Hold write data on sysbus
            default: begin
               AluEn = storeOp;
               RegWe = !storeOp;
               WdSel = storeOp ? controlPkg::WdAlu : controlPkg::WdSys;
               PcWe  = 1'b1;
            end
         endcase
      end else if (opcode == isaPkg::BRANCH) begin
         PcWe = 1'b1;
         if (branchCode == isaPkg::RET) begin
            LrEn  = 1'b1;
            PcSel = controlPkg::PcSysbus;
         end else begin
            AluOp  = controlPkg::FnADD;   // PC plus long offset
            Op1Sel = controlPkg::Op1Pc;
            AluEn  = 1'b1;
            PcSel  = branchTaken ? controlPkg::PcAluOut : controlPkg::Pc1;
            LrWe   = branchTaken && (branchCode == isaPkg::BWL);
         end
      end else begin
         PcWe = 1'b1;   // Unused opcode, skip it
      end
   end

endmodule

/* source/flagUnit.sv */
// Status register and branch condition evaluation
`timescale 1ns/1ps

module flagUnit (
   input  logic                           Clock,
   input  logic                           nReset,
   input  logic [isaPkg::FlagCount-1:0]   Flags,
   input  logic                           statusWe,
   input  logic [isaPkg::BranchWidth-1:0] branchCode,
   output logic                           CFlag,
   output logic                           branchTaken
);

   logic [isaPkg::FlagCount-1:0] statusReg;
   logic                         signedLess;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         statusReg <= '0;
      else if (statusWe)
         statusReg <= Flags;
   end

   assign CFlag      = statusReg[isaPkg::FlagC];
   assign signedLess = statusReg[isaPkg::FlagN] ^ statusReg[isaPkg::FlagV];

   always_comb begin
      case (branchCode)
         isaPkg::BR, isaPkg::BWL: branchTaken = 1'b1;
         isaPkg::BNE:             branchTaken = !statusReg[isaPkg::FlagZ];
         isaPkg::BE:              branchTaken = statusReg[isaPkg::FlagZ];
         isaPkg::BLT:             branchTaken = signedLess;
         isaPkg::BGE:             branchTaken = !signedLess;
         default:                 branchTaken = 1'b0;   // RET and unused code
      endcase
   end

endmodule

/* source/stepSequencer.sv */
// Fetch/execute step sequencer, stalls on nWait at the memory data steps
`timescale 1ns/1ps

module stepSequencer (
   input  logic      Clock,
   input  logic      nReset,
   input  logic      nWait,
   cycleIf.sequencer cyc
);

   logic                             inFetch;
   logic [controlPkg::StepWidth-1:0] step;
   logic                             lastStep;
   logic                             stall;

   always_comb begin
      if (inFetch) begin
         lastStep = step == controlPkg::Step3;
         stall    = !nWait && (step == controlPkg::Step2);
      end else begin
         // Non-memory instructions finish in their first step
         lastStep = (step == controlPkg::Step4) ||
                    (step == controlPkg::Step0 && !cyc.memoryOp);
         stall    = !nWait && (step == controlPkg::Step3);
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         inFetch <= 1'b1;
         step    <= controlPkg::Step0;
      end else if (lastStep) begin
         inFetch <= !inFetch;                // Swap phase
         step    <= controlPkg::Step0;
      end else if (!stall) begin
         step    <= step + 1'b1;
      end
   end

   assign cyc.inFetch = inFetch;
   assign cyc.step    = step;

endmodule

/* source/cycleIf.sv */
// Instruction phase and step shared by the sequencer, decoder and bus control
`timescale 1ns/1ps

interface cycleIf;

   logic                             inFetch;
   logic [controlPkg::StepWidth-1:0] step;
   logic                             memoryOp;   // LDW or STW in the IR
   logic                             storeOp;

   modport sequencer (output inFetch, output step, input memoryOp);

   modport decoder (input inFetch, input step, output memoryOp, output storeOp);

   modport bus (input inFetch, input step, input storeOp);

endinterface

/* source/controlPkg.sv */
// Datapath control codes driven by the control unit: ALU functions, selects, steps
package controlPkg;

   localparam int AluFnWidth = 4;

   localparam logic [AluFnWidth-1:0] FnA    = 4'd0;
   localparam logic [AluFnWidth-1:0] FnADD  = 4'd1;
   localparam logic [AluFnWidth-1:0] FnADC  = 4'd2;
   localparam logic [AluFnWidth-1:0] FnSUB  = 4'd3;
   localparam logic [AluFnWidth-1:0] FnNEG  = 4'd4;
   localparam logic [AluFnWidth-1:0] FnAND  = 4'd5;
   localparam logic [AluFnWidth-1:0] FnOR   = 4'd6;
   localparam logic [AluFnWidth-1:0] FnXOR  = 4'd7;
   localparam logic [AluFnWidth-1:0] FnNOR  = 4'd8;
   localparam logic [AluFnWidth-1:0] FnNAND = 4'd9;
   localparam logic [AluFnWidth-1:0] FnNOT  = 4'd10;
   localparam logic [AluFnWidth-1:0] FnLSL  = 4'd11;
   localparam logic [AluFnWidth-1:0] FnLSR  = 4'd12;
   localparam logic [AluFnWidth-1:0] FnASR  = 4'd13;
   localparam logic [AluFnWidth-1:0] FnLUI  = 4'd14;
   localparam logic [AluFnWidth-1:0] FnLLI  = 4'd15;

   localparam logic Op1Rd1   = 1'b0;
   localparam logic Op1Pc    = 1'b1;
   localparam logic Op2Imm   = 1'b0;
   localparam logic Op2Rd2   = 1'b1;
   localparam logic ImmLong  = 1'b0;
   localparam logic ImmShort = 1'b1;
   localparam logic WdAlu    = 1'b0;
   localparam logic WdSys    = 1'b1;
   localparam logic Rs1Ra    = 1'b0;
   localparam logic Rs1Rd    = 1'b1;

   localparam int PcSelWidth = 2;
   localparam logic [PcSelWidth-1:0] Pc1      = 2'd0;
   localparam logic [PcSelWidth-1:0] PcAluOut = 2'd1;
   localparam logic [PcSelWidth-1:0] PcSysbus = 2'd2;

   localparam int StepWidth = 3;
   localparam logic [StepWidth-1:0] Step0 = 3'd0;
   localparam logic [StepWidth-1:0] Step1 = 3'd1;
   localparam logic [StepWidth-1:0] Step2 = 3'd2;
   localparam logic [StepWidth-1:0] Step3 = 3'd3;
   localparam logic [StepWidth-1:0] Step4 = 3'd4;

endpackage

/* source/isaPkg.sv */
// Instruction set of the 16-bit RISC core: field positions, opcodes, branch codes, flags
package isaPkg;

   localparam int InstrWidth  = 8;
   localparam int OpcodeWidth = 5;
   localparam int OpcodeMsb   = 7;
   localparam int OpcodeLsb   = 3;
   localparam int BranchWidth = 3;

   localparam logic [OpcodeWidth-1:0] ADD    = 5'd0;
   localparam logic [OpcodeWidth-1:0] ADDI   = 5'd1;
   localparam logic [OpcodeWidth-1:0] ADDIB  = 5'd2;
   localparam logic [OpcodeWidth-1:0] ADC    = 5'd3;
   localparam logic [OpcodeWidth-1:0] ADCI   = 5'd4;
   localparam logic [OpcodeWidth-1:0] SUB    = 5'd5;
   localparam logic [OpcodeWidth-1:0] SUBI   = 5'd6;
   localparam logic [OpcodeWidth-1:0] SUBIB  = 5'd7;
   localparam logic [OpcodeWidth-1:0] SUC    = 5'd8;
   localparam logic [OpcodeWidth-1:0] SUCI   = 5'd9;
   localparam logic [OpcodeWidth-1:0] NEG    = 5'd10;
   localparam logic [OpcodeWidth-1:0] CMP    = 5'd11;
   localparam logic [OpcodeWidth-1:0] CMPI   = 5'd12;
   localparam logic [OpcodeWidth-1:0] AND    = 5'd13;
   localparam logic [OpcodeWidth-1:0] OR     = 5'd14;
   localparam logic [OpcodeWidth-1:0] XOR    = 5'd15;
   localparam logic [OpcodeWidth-1:0] NOR    = 5'd16;
   localparam logic [OpcodeWidth-1:0] NAND   = 5'd17;
   localparam logic [OpcodeWidth-1:0] NOT    = 5'd18;
   localparam logic [OpcodeWidth-1:0] LSL    = 5'd19;
   localparam logic [OpcodeWidth-1:0] LSR    = 5'd20;
   localparam logic [OpcodeWidth-1:0] ASR    = 5'd21;
   localparam logic [OpcodeWidth-1:0] LUI    = 5'd22;
   localparam logic [OpcodeWidth-1:0] LLI    = 5'd23;
   localparam logic [OpcodeWidth-1:0] LDW    = 5'd24;
   localparam logic [OpcodeWidth-1:0] STW    = 5'd25;
   localparam logic [OpcodeWidth-1:0] BRANCH = 5'd26;

   // Condition field of the BRANCH group
   localparam logic [BranchWidth-1:0] BR  = 3'd0;
   localparam logic [BranchWidth-1:0] BNE = 3'd1;
   localparam logic [BranchWidth-1:0] BE  = 3'd2;
   localparam logic [BranchWidth-1:0] BLT = 3'd3;
   localparam logic [BranchWidth-1:0] BGE = 3'd4;
   localparam logic [BranchWidth-1:0] BWL = 3'd5;
   localparam logic [BranchWidth-1:0] RET = 3'd6;

   localparam int FlagC     = 0;
   localparam int FlagZ     = 1;
   localparam int FlagN     = 2;
   localparam int FlagV     = 3;
   localparam int FlagCount = 4;

endpackage
